//--- flist.f
common/tracer_pkg.sv
design/scene_buffer.sv
ray_tracer/ray_intersector.sv
ray_tracer/reflect_geometry.sv
ray_tracer/reflect_shade.sv
ray_tracer/ray_reflector.sv
ray_tracer/ray_tracer.sv
design/trace_unit.sv
verif/tb_trace_unit.sv

//--- Makefile
# Verilator build for the trace unit

VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_trace_unit
RTL_TOP    ?= trace_unit
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_trace_unit.sv
`timescale 1ns/1ps

module tb_trace_unit import tracer_pkg::*; ();

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_SWEEP       = 10;
  localparam int NUM_RAYS        = 5 + NUM_SWEEP;
  localparam int RAY_CYCLES      = (MAX_BOUNCES + 1) * 40;
  localparam int WATCHDOG_CYCLES = NUM_RAYS * RAY_CYCLES + 3000;
  localparam int ISECT_CYCLES    = NUM_OBJECTS + 1;
  localparam int REFL_CYCLES     = 19;
  localparam int BOUNCE_CYCLES   = ISECT_CYCLES + REFL_CYCLES;
  localparam coord LARGEST_COORD = 16'sh7fff;

  logic                     clk;
  logic                     rst;
  logic                     scene_we;
  logic [OBJ_ADDR_BITS-1:0] scene_addr;
  object                    scene_obj;
  logic                     ray_valid;
  vec3                      ray_origin;
  vec3                      ray_dir;
  logic [10:0]              pixel_h;
  logic [9:0]               pixel_v;
  logic                     ray_done;
  color                     pixel_color;
  logic [10:0]              pixel_h_out;
  logic [9:0]               pixel_v_out;

  // Scene as loaded into the DUT and read by the model
  object       scene [NUM_OBJECTS];
  logic [15:0] lfsr;
  int          errors;
  int          checks;

  trace_unit dut (
    .clk         (clk),
    .rst         (rst),
    .scene_we    (scene_we),
    .scene_addr  (scene_addr),
    .scene_obj   (scene_obj),
    .ray_valid   (ray_valid),
    .ray_origin  (ray_origin),
    .ray_dir     (ray_dir),
    .pixel_h     (pixel_h),
    .pixel_v     (pixel_v),
    .ray_done    (ray_done),
    .pixel_color (pixel_color),
    .pixel_h_out (pixel_h_out),
    .pixel_v_out (pixel_v_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic color rgb(logic [7:0] r, logic [7:0] g, logic [7:0] b);
    color c;
    c.r = r;
    c.g = g;
    c.b = b;
    return c;
  endfunction

  function automatic vec3 xyz(coord x, coord y, coord z);
    vec3 v;
    v.x = x;
    v.y = y;
    v.z = z;
    return v;
  endfunction

  function automatic object make_obj(logic en, axis_sel ax, coord pos, mat_kind kind, color c);
    object o;
    o.en       = en;
    o.axis     = ax;
    o.pos      = pos;
    o.mat.kind = kind;
    if (kind == MAT_MIRROR) begin
      o.mat.payload.albedo = c;
    end else begin
      o.mat.payload.emission = c;
    end
    return o;
  endfunction

  function automatic coord axis_component(vec3 v, axis_sel a);
    case (a)
      AXIS_X:  return v.x;
      AXIS_Y:  return v.y;
      default: return v.z;
    endcase
  endfunction

  function automatic logic [15:0] magnitude(coord c);
    return c[15] ? 16'(-c) : 16'(c);
  endfunction

  function automatic color scale_color(color a, color b);
    logic [15:0] pr;
    logic [15:0] pg;
    logic [15:0] pb;
    pr = a.r * b.r;
    pg = a.g * b.g;
    pb = a.b * b.b;
    return rgb(pr[15:8], pg[15:8], pb[15:8]);
  endfunction

  function automatic color add_sat(color a, color b);
    logic [8:0] sr;
    logic [8:0] sg;
    logic [8:0] sb;
    sr = a.r + b.r;
    sg = a.g + b.g;
    sb = a.b + b.b;
    return rgb(sr[8] ? 8'hff : sr[7:0], sg[8] ? 8'hff : sg[7:0], sb[8] ? 8'hff : sb[7:0]);
  endfunction

  // Reference model of the whole bounce loop
  function automatic color model_trace(vec3 org, vec3 dir);
    color               col;
    color               light;
    int                 best;
    coord               num;
    coord               den;
    coord               bnum;
    coord               bden;
    coord               t;
    logic [31:0]        lhs;
    logic [31:0]        rhs;
    logic [31:0]        q;
    logic signed [31:0] px;
    logic signed [31:0] py;
    logic signed [31:0] pz;
    col   = rgb(WHITE, WHITE, WHITE);
    light = rgb(8'd0, 8'd0, 8'd0);
    bnum  = '0;
    bden  = '0;
    for (int b = 0; b < MAX_BOUNCES; b++) begin
      best = -1;
      for (int i = 0; i < NUM_OBJECTS; i++) begin
        num = scene[i].pos - axis_component(org, scene[i].axis);
        den = axis_component(dir, scene[i].axis);
        if (scene[i].en && den != 0 && num != 0 && num[15] == den[15]) begin
          lhs = magnitude(num) * magnitude(bden);
          rhs = magnitude(bnum) * magnitude(den);
          if (best < 0 || lhs < rhs) begin
            best = i;
            bnum = num;
            bden = den;
          end
        end
      end
      if (best < 0) begin
        return light;
      end
      if (scene[best].mat.kind == MAT_EMITTER) begin
        return add_sat(light, scale_color(col, scene[best].mat.payload.emission));
      end
      col = scale_color(col, scene[best].mat.payload.albedo);
      // Distance along the ray and the bounce point
      q  = {8'b0, magnitude(bnum), 8'b0} / {16'b0, magnitude(bden)};
      t  = (q > 32'd32767) ? LARGEST_COORD : coord'(q[15:0]);
      px = dir.x * t;
      py = dir.y * t;
      pz = dir.z * t;
      org.x = org.x + coord'(px >>> FRAC_BITS);
      org.y = org.y + coord'(py >>> FRAC_BITS);
      org.z = org.z + coord'(pz >>> FRAC_BITS);
      case (scene[best].axis)
        AXIS_X: begin
          org.x = scene[best].pos;
          dir.x = -dir.x;
        end
        AXIS_Y: begin
          org.y = scene[best].pos;
          dir.y = -dir.y;
        end
        default: begin
          org.z = scene[best].pos;
          dir.z = -dir.z;
        end
      endcase
    end
    return light;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic clear_scene();
    for (int i = 0; i < NUM_OBJECTS; i++) begin
      scene[i] = make_obj(1'b0, AXIS_X, '0, MAT_MIRROR, rgb(8'd0, 8'd0, 8'd0));
    end
  endtask

  task automatic load_scene();
    for (int i = 0; i < NUM_OBJECTS; i++) begin
      @(posedge clk);
      #1;
      scene_we   = 1'b1;
      scene_addr = OBJ_ADDR_BITS'(i);
      scene_obj  = scene[i];
    end
    @(posedge clk);
    #1;
    scene_we = 1'b0;
  endtask

  task automatic launch_ray(vec3 org, vec3 dir, logic [10:0] h, logic [9:0] v);
    @(posedge clk);
    #1;
    ray_valid  = 1'b1;
    ray_origin = org;
    ray_dir    = dir;
    pixel_h    = h;
    pixel_v    = v;
    @(posedge clk);
    #1;
    ray_valid = 1'b0;
  endtask

  // Sampled 1 ns after the edge where registered outputs have settled
  task automatic wait_ray_done(output bit seen);
    seen = 1'b0;
    for (int n = 0; n < RAY_CYCLES && !seen; n++) begin
      @(posedge clk);
      #1;
      seen = ray_done;
    end
  endtask

  task automatic trace_and_check(string name, vec3 org, vec3 dir, logic [10:0] h,
                                 logic [9:0] v);
    color expected;
    bit   seen;
    expected = model_trace(org, dir);
    launch_ray(org, dir, h, v);
    wait_ray_done(seen);
    if (!seen) begin
      errors++;
      $display("Error %s: no ray_done within %0d cycles", name, RAY_CYCLES);
    end else begin
      check_value({name, " color"}, expected, pixel_color);
      check_value({name, " pixel_h"}, h, pixel_h_out);
      check_value({name, " pixel_v"}, v, pixel_v_out);
    end
  endtask

  // Planes behind the ray or parallel to it
  task automatic miss_scene();
    clear_scene();
    scene[0] = make_obj(1'b1, AXIS_X, -16'sd1024, MAT_MIRROR, rgb(8'd255, 8'd255, 8'd255));
    scene[1] = make_obj(1'b1, AXIS_Y, 16'sd512, MAT_EMITTER, rgb(8'd255, 8'd0, 8'd0));
    scene[2] = make_obj(1'b1, AXIS_Z, 16'sd512, MAT_EMITTER, rgb(8'd0, 8'd255, 8'd0));
    load_scene();
    check_value("miss model", 32'd0, model_trace(xyz(0, 0, 0), xyz(256, 0, -128)));
    trace_and_check("miss", xyz(0, 0, 0), xyz(256, 0, -128), 11'd1234, 10'd567);
  endtask

  task automatic direct_emitter();
    clear_scene();
    scene[3] = make_obj(1'b1, AXIS_Z, 16'sd768, MAT_EMITTER, rgb(8'd200, 8'd100, 8'd50));
    load_scene();
    trace_and_check("direct_emitter", xyz(0, 0, 0), xyz(0, 0, 256), 11'd2047, 10'd1023);
  endtask

  // Emitter behind the start is reachable only after the mirror
  task automatic mirror_to_emitter();
    clear_scene();
    scene[0] = make_obj(1'b1, AXIS_X, 16'sd512, MAT_MIRROR, rgb(8'd128, 8'd255, 8'd64));
    scene[1] = make_obj(1'b1, AXIS_X, -16'sd512, MAT_EMITTER, rgb(8'd240, 8'd200, 8'd160));
    load_scene();
    trace_and_check("mirror_to_emitter", xyz(0, 0, 0), xyz(256, 0, 128), 11'd17, 10'd33);
  endtask

  task automatic nearest_plane();
    clear_scene();
    scene[0] = make_obj(1'b0, AXIS_X, 16'sd256, MAT_EMITTER, rgb(8'd255, 8'd0, 8'd0));
    scene[1] = make_obj(1'b1, AXIS_Z, 16'sd1536, MAT_EMITTER, rgb(8'd0, 8'd0, 8'd255));
    scene[2] = make_obj(1'b1, AXIS_Y, 16'sd768, MAT_EMITTER, rgb(8'd0, 8'd255, 8'd0));
    scene[3] = make_obj(1'b1, AXIS_X, 16'sd1024, MAT_EMITTER, rgb(8'd255, 8'd255, 8'd255));
    scene[4] = make_obj(1'b1, AXIS_Z, -16'sd512, MAT_MIRROR, rgb(8'd90, 8'd90, 8'd90));
    load_scene();
    trace_and_check("nearest_plane", xyz(128, -256, 64), xyz(256, 256, 256), 11'd640,
                    10'd480);
  endtask

  // Facing mirrors and a second ray_valid while the first is in flight
  task automatic bounce_limit();
    color expected;
    bit   seen;
    time  launched;
    int   latency;
    clear_scene();
    scene[0] = make_obj(1'b1, AXIS_X, 16'sd1024, MAT_MIRROR, rgb(8'd200, 8'd200, 8'd200));
    scene[1] = make_obj(1'b1, AXIS_X, -16'sd1024, MAT_MIRROR, rgb(8'd200, 8'd200, 8'd200));
    load_scene();
    expected = model_trace(xyz(0, 0, 0), xyz(256, 64, 0));
    launch_ray(xyz(0, 0, 0), xyz(256, 64, 0), 11'd100, 10'd200);
    launched = $time;
    repeat (18) @(posedge clk);
    launch_ray(xyz(0, 0, 0), xyz(0, 0, 256), 11'd999, 10'd999);
    wait_ray_done(seen);
    if (!seen) begin
      errors++;
      $display("Error bounce_limit: no ray_done within %0d cycles", RAY_CYCLES);
    end else begin
      latency = int'(($time - launched) / CLK_PERIOD);
      check_value("bounce_limit color", expected, pixel_color);
      check_value("bounce_limit pixel_h", 11'd100, pixel_h_out);
      check_value("bounce_limit pixel_v", 10'd200, pixel_v_out);
      // Each reflection costs at least one scan and one reflector pass
      checks++;
      if (latency < MAX_BOUNCES * BOUNCE_CYCLES ||
          latency >= (MAX_BOUNCES + 1) * BOUNCE_CYCLES) begin
        errors++;
        $display("Error bounce_limit: ray_done after %0d cycles, not after %0d reflections",
                 latency, MAX_BOUNCES);
      end
    end
    wait_ray_done(seen);
    if (seen) begin
      errors++;
      $display("Error bounce_limit: a ray_valid sent in flight produced a second ray_done");
    end
  endtask

  task automatic random_sweep();
    logic [31:0] r;
    vec3         dir;
    coord        zmag;
    logic [10:0] h;
    logic [9:0]  v;
    color        alb_a;
    color        alb_b;
    color        emis;
    for (int k = 0; k < NUM_SWEEP; k++) begin
      take_bits(24, r);
      alb_a = r[23:0];
      take_bits(24, r);
      alb_b = r[23:0];
      take_bits(24, r);
      emis = r[23:0];
      take_bits(11, r);
      h = r[10:0];
      take_bits(10, r);
      v = r[9:0];
      take_bits(1, r);
      dir.x = r[0] ? -16'sd256 : 16'sd256;
      take_bits(1, r);
      dir.y = r[0] ? -16'sd128 : 16'sd128;
      take_bits(7, r);
      zmag = 16'sd64 + coord'(r[6:0]);
      take_bits(1, r);
      dir.z = r[0] ? -zmag : zmag;
      clear_scene();
      scene[0] = make_obj(1'b1, AXIS_X, 16'sd1024, MAT_MIRROR, alb_a);
      scene[1] = make_obj(1'b1, AXIS_X, -16'sd1024, MAT_MIRROR, alb_b);
      scene[2] = make_obj(1'b1, AXIS_Z, 16'sd1024, MAT_EMITTER, emis);
      load_scene();
      trace_and_check($sformatf("sweep %0d", k), xyz(0, 0, 0), dir, h, v);
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    scene_we   = 1'b0;
    scene_addr = '0;
    scene_obj  = '0;
    ray_valid  = 1'b0;
    ray_origin = '0;
    ray_dir    = '0;
    pixel_h    = '0;
    pixel_v    = '0;
    errors     = 0;
    checks     = 0;
    lfsr       = 16'd36417;
    clear_scene();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    miss_scene();
    direct_emitter();
    mirror_to_emitter();
    nearest_plane();
    bounce_limit();
    random_sweep();

    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- design/trace_unit.sv
`timescale 1ns/1ps

module trace_unit import tracer_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     scene_we,
  input  logic [OBJ_ADDR_BITS-1:0] scene_addr,
  input  object                    scene_obj,
  input  logic                     ray_valid,
  input  vec3                      ray_origin,
  input  vec3                      ray_dir,
  input  logic [10:0]              pixel_h,
  input  logic [9:0]               pixel_v,
  output logic                     ray_done,
  output color                     pixel_color,
  output logic [10:0]              pixel_h_out,
  output logic [9:0]               pixel_v_out
);

  logic [OBJ_ADDR_BITS-1:0] obj_addr;
  object                    obj;

  scene_buffer u_scene (
    .clk   (clk),
    .rst   (rst),
    .we    (scene_we),
    .waddr (scene_addr),
    .wobj  (scene_obj),
    .raddr (obj_addr),
    .robj  (obj)
  );

  ray_tracer u_tracer (
    .clk         (clk),
    .rst         (rst),
    .ray_valid   (ray_valid),
    .ray_origin  (ray_origin),
    .ray_dir     (ray_dir),
    .pixel_h     (pixel_h),
    .pixel_v     (pixel_v),
    .obj_addr    (obj_addr),
    .obj         (obj),
    .ray_done    (ray_done),
    .pixel_color (pixel_color),
    .pixel_h_out (pixel_h_out),
    .pixel_v_out (pixel_v_out)
  );

endmodule

//--- ray_tracer/ray_tracer.sv
`timescale 1ns/1ps

module ray_tracer import tracer_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ray_valid,
  input  vec3                      ray_origin,
  input  vec3                      ray_dir,
  input  logic [10:0]              pixel_h,
  input  logic [9:0]               pixel_v,
  output logic [OBJ_ADDR_BITS-1:0] obj_addr,
  input  object                    obj,
  output logic                     ray_done,
  output color                     pixel_color,
  output logic [10:0]              pixel_h_out,
  output logic [9:0]               pixel_v_out
);

  typedef enum logic [1:0] {
    IDLE,
    INTX,
    REFLECT
  } state_t;

  state_t  state;
  logic    isect_start;
  logic    isect_done;
  logic    refl_start;
  logic    refl_done;
  hit_info hit;
  vec3     cur_origin;
  vec3     cur_dir;
  color    cur_color;
  color    cur_light;
  vec3     refl_origin;
  vec3     refl_dir;
  color    refl_color;
  color    refl_light;
  logic [10:0] pix_h_q;
  logic [9:0]  pix_v_q;
  logic [$clog2(MAX_BOUNCES)-1:0] bounce;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      isect_start <= 1'b0;
      refl_start  <= 1'b0;
      ray_done    <= 1'b0;
      bounce      <= '0;
    end else begin
      isect_start <= 1'b0;
      refl_start  <= 1'b0;
      ray_done    <= 1'b0;
      case (state)
        IDLE: begin
          if (ray_valid) begin
            bounce      <= '0;
            isect_start <= 1'b1;
            state       <= INTX;
          end
        end
        INTX: begin
          if (isect_done) begin
            if (hit.any) begin
              refl_start <= 1'b1;
              state      <= REFLECT;
            end else begin
              // Missed everything
              ray_done <= 1'b1;
              state    <= IDLE;
            end
          end
        end
        REFLECT: begin
          if (refl_done) begin
            if (hit.mat.kind == MAT_EMITTER ||
                bounce == $bits(bounce)'(MAX_BOUNCES - 1)) begin
              ray_done <= 1'b1;
              state    <= IDLE;
            end else begin
              bounce      <= bounce + 1'b1;
              isect_start <= 1'b1;
              state       <= INTX;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Ray state and results
  always_ff @(posedge clk) begin
    if (state == IDLE && ray_valid) begin
      cur_origin <= ray_origin;
      cur_dir    <= ray_dir;
      cur_color  <= '{r: WHITE, g: WHITE, b: WHITE};
      cur_light  <= '0;
      pix_h_q    <= pixel_h;
      pix_v_q    <= pixel_v;
    end
    if (state == INTX && isect_done && !hit.any) begin
      pixel_color <= cur_light;
      pixel_h_out <= pix_h_q;
      pixel_v_out <= pix_v_q;
    end
    if (state == REFLECT && refl_done) begin
      cur_origin  <= refl_origin;
      cur_dir     <= refl_dir;
      cur_color   <= refl_color;
      cur_light   <= refl_light;
      pixel_color <= refl_light;
      pixel_h_out <= pix_h_q;
      pixel_v_out <= pix_v_q;
    end
  end

  ray_intersector u_intersector (
    .clk      (clk),
    .rst      (rst),
    .start    (isect_start),
    .origin   (cur_origin),
    .dir      (cur_dir),
    .obj_addr (obj_addr),
    .obj      (obj),
    .hit      (hit),
    .done     (isect_done)
  );

  ray_reflector u_reflector (
    .clk        (clk),
    .rst        (rst),
    .start      (refl_start),
    .origin     (cur_origin),
    .dir        (cur_dir),
    .color_in   (cur_color),
    .light_in   (cur_light),
    .hit        (hit),
    .new_origin (refl_origin),
    .new_dir    (refl_dir),
    .new_color  (refl_color),
    .new_light  (refl_light),
    .done       (refl_done)
  );

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    ray_done |=> !ray_done);

endmodule

//--- ray_tracer/ray_reflector.sv
`timescale 1ns/1ps

module ray_reflector import tracer_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  vec3     origin,
  input  vec3     dir,
  input  color    color_in,
  input  color    light_in,
  input  hit_info hit,
  output vec3     new_origin,
  output vec3     new_dir,
  output color    new_color,
  output color    new_light,
  output logic    done
);

  logic geo_done;
  logic shade_done;
  logic geo_fin;
  logic shade_fin;
  logic geo_seen;
  logic shade_seen;
  logic both;
  vec3  geo_origin;
  vec3  geo_dir;
  color shade_color;
  color shade_light;

  reflect_geometry u_geometry (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .origin     (origin),
    .dir        (dir),
    .hit        (hit),
    .new_origin (geo_origin),
    .new_dir    (geo_dir),
    .done       (geo_done)
  );

  reflect_shade u_shade (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .color_in  (color_in),
    .light_in  (light_in),
    .mat       (hit.mat),
    .new_color (shade_color),
    .new_light (shade_light),
    .done      (shade_done)
  );

  assign geo_seen   = geo_fin | geo_done;
  assign shade_seen = shade_fin | shade_done;
  assign both       = geo_seen && shade_seen;

  always_ff @(posedge clk) begin
    if (rst) begin
      geo_fin   <= 1'b0;
      shade_fin <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start || both) begin
        geo_fin   <= 1'b0;
        shade_fin <= 1'b0;
        done      <= both && !start;
      end else begin
        geo_fin   <= geo_seen;
        shade_fin <= shade_seen;
      end
    end
  end

  // Children hold their outputs, so the join samples both at once
  always_ff @(posedge clk) begin
    if (both && !start) begin
      new_origin <= geo_origin;
      new_dir    <= geo_dir;
      new_color  <= shade_color;
      new_light  <= shade_light;
    end
  end

endmodule

//--- ray_tracer/reflect_shade.sv
`timescale 1ns/1ps

module reflect_shade import tracer_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  color    color_in,
  input  color    light_in,
  input  material mat,
  output color    new_color,
  output color    new_light,
  output logic    done
);

  logic    stage;
  color    factor;
  color    prod;
  mat_kind kind_q;

  function automatic logic [7:0] chan_mul(logic [7:0] a, logic [7:0] b);
    logic [15:0] p;
    p = a * b;
    return p[15:8];
  endfunction

  function automatic logic [7:0] sat_add(logic [7:0] a, logic [7:0] b);
    logic [8:0] s;
    s = a + b;
    return s[8] ? 8'hff : s[7:0];
  endfunction

  // Albedo and emission share one payload word
  assign factor = mat.payload;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage <= 1'b0;
      done  <= 1'b0;
    end else begin
      stage <= start;
      done  <= stage;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      prod.r <= chan_mul(color_in.r, factor.r);
      prod.g <= chan_mul(color_in.g, factor.g);
      prod.b <= chan_mul(color_in.b, factor.b);
      kind_q <= mat.kind;
    end
    if (stage) begin
      if (kind_q == MAT_MIRROR) begin
        new_color <= prod;
        new_light <= light_in;
      end else begin
        new_color   <= color_in;
        new_light.r <= sat_add(light_in.r, prod.r);
        new_light.g <= sat_add(light_in.g, prod.g);
        new_light.b <= sat_add(light_in.b, prod.b);
      end
    end
  end

endmodule

//--- ray_tracer/reflect_geometry.sv
`timescale 1ns/1ps

module reflect_geometry import tracer_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  vec3     origin,
  input  vec3     dir,
  input  hit_info hit,
  output vec3     new_origin,
  output vec3     new_dir,
  output logic    done
);

  logic        busy;
  logic        pos_stage;
  logic [3:0]  step;
  logic [15:0] dvs;
  logic [15:0] rem;
  logic [15:0] quo;
  logic [15:0] dvd_lo;
  logic        ovf;
  logic [16:0] trial;
  logic [15:0] num_mag;
  logic [15:0] den_mag;
  coord        t;
  vec3         pos_c;
  vec3         dir_c;

  // One component of origin + dir * t
  function automatic coord step_comp(coord o, coord d, coord tt);
    logic signed [31:0] p;
    p = d * tt;
    return o + coord'(p >>> FRAC_BITS);
  endfunction

  assign num_mag = abs_coord(hit.num);
  assign den_mag = abs_coord(hit.den);
  assign trial   = {rem, dvd_lo[15]};

  // Quotient over 16 bits or past the coord range saturates
  assign t = (ovf || quo[15]) ? COORD_MAX : coord'(quo);

  always_comb begin
    pos_c.x = step_comp(origin.x, dir.x, t);
    pos_c.y = step_comp(origin.y, dir.y, t);
    pos_c.z = step_comp(origin.z, dir.z, t);
    dir_c   = dir;
    // Snap onto the plane and flip the normal component
    case (hit.axis)
      AXIS_X: begin
        pos_c.x = hit.pos;
        dir_c.x = -dir.x;
      end
      AXIS_Y: begin
        pos_c.y = hit.pos;
        dir_c.y = -dir.y;
      end
      default: begin
        pos_c.z = hit.pos;
        dir_c.z = -dir.z;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      pos_stage <= 1'b0;
      step      <= '0;
      done      <= 1'b0;
    end else begin
      done      <= pos_stage;
      pos_stage <= busy && (step == 4'd15);
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == 4'd15) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // Restoring divide of |num| << 8 by |den|, one quotient bit per cycle
  always_ff @(posedge clk) begin
    if (start) begin
      dvs    <= den_mag;
      rem    <= {8'b0, num_mag[15:8]};
      dvd_lo <= {num_mag[7:0], 8'b0};
      quo    <= '0;
      ovf    <= ({8'b0, num_mag} >= {den_mag, 8'b0});
    end else if (busy) begin
      dvd_lo <= dvd_lo << 1;
      if (trial >= {1'b0, dvs}) begin
        rem <= 16'(trial - {1'b0, dvs});
        quo <= {quo[14:0], 1'b1};
      end else begin
        rem <= trial[15:0];
        quo <= {quo[14:0], 1'b0};
      end
    end
    if (pos_stage) begin
      new_origin <= pos_c;
      new_dir    <= dir_c;
    end
  end

  a_no_restart: assert property (@(posedge clk) disable iff (rst)
    start |-> !busy && !pos_stage);

endmodule

//--- ray_tracer/ray_intersector.sv
`timescale 1ns/1ps

module ray_intersector import tracer_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  vec3                      origin,
  input  vec3                      dir,
  output logic [OBJ_ADDR_BITS-1:0] obj_addr,
  input  object                    obj,
  output hit_info                  hit,
  output logic                     done
);

  logic        busy;
  logic        last_addr;
  hit_info     best;
  hit_info     cand;
  logic        cand_ok;
  logic        cand_wins;
  coord        o_c;
  coord        d_c;
  logic [15:0] cand_num_mag;
  logic [15:0] cand_den_mag;
  logic [15:0] best_num_mag;
  logic [15:0] best_den_mag;
  logic [31:0] lhs;
  logic [31:0] rhs;

  assign last_addr = (obj_addr == OBJ_ADDR_BITS'(NUM_OBJECTS - 1));

  always_comb begin
    o_c = vec_comp(origin, obj.axis);
    d_c = vec_comp(dir, obj.axis);

    cand.axis = obj.axis;
    cand.num  = obj.pos - o_c;
    cand.den  = d_c;
    cand.pos  = obj.pos;
    cand.mat  = obj.mat;

    // Plane must lie ahead of the ray
    cand_ok = obj.en && (cand.den != '0) && (cand.num != '0) &&
              (cand.num[15] == cand.den[15]);
    cand.any = cand_ok;

    cand_num_mag = abs_coord(cand.num);
    cand_den_mag = abs_coord(cand.den);
    best_num_mag = abs_coord(best.num);
    best_den_mag = abs_coord(best.den);

    // Compare num/den ratios without dividing
    lhs = cand_num_mag * best_den_mag;
    rhs = best_num_mag * cand_den_mag;

    // Strict compare keeps the lower address on a tie
    cand_wins = cand_ok && (!best.any || (lhs < rhs));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      obj_addr <= '0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy     <= 1'b1;
        obj_addr <= '0;
      end else if (busy) begin
        if (last_addr) begin
          busy     <= 1'b0;
          done     <= 1'b1;
          obj_addr <= '0;
        end else begin
          obj_addr <= obj_addr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      best.any <= 1'b0;
    end else if (busy && cand_wins) begin
      best <= cand;
    end
    // Final slot goes straight into the result
    if (busy && last_addr) begin
      hit <= cand_wins ? cand : best;
    end
  end

  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    start |-> !busy);

endmodule

//--- design/scene_buffer.sv
`timescale 1ns/1ps

module scene_buffer import tracer_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     we,
  input  logic [OBJ_ADDR_BITS-1:0] waddr,
  input  object                    wobj,
  input  logic [OBJ_ADDR_BITS-1:0] raddr,
  output object                    robj
);

  object mem [NUM_OBJECTS];

  // Reset clears only the enable bits
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_OBJECTS; i++) begin
        mem[i].en <= 1'b0;
      end
    end else if (we) begin
      mem[waddr] <= wobj;
    end
  end

  // Combinational read for the intersector
  assign robj = mem[raddr];

endmodule

//--- common/tracer_pkg.sv
package tracer_pkg;

  // Fixed point and scene sizing
  localparam int FRAC_BITS     = 8;
  localparam int NUM_OBJECTS   = 8;
  localparam int OBJ_ADDR_BITS = 3;
  localparam int MAX_BOUNCES   = 4;
  localparam logic [7:0] WHITE = 8'd255;

  typedef logic signed [15:0] coord;

  localparam coord COORD_MAX = 16'sh7fff;

  typedef struct packed {
    coord x;
    coord y;
    coord z;
  } vec3;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } color;

  typedef enum logic {
    MAT_MIRROR  = 1'b0,
    MAT_EMITTER = 1'b1
  } mat_kind;

  // Mirrors read the word as albedo, emitters as emitted light
  typedef union packed {
    color albedo;
    color emission;
  } mat_payload;

  typedef struct packed {
    mat_kind    kind;
    mat_payload payload;
  } material;

  typedef enum logic [1:0] {
    AXIS_X = 2'd0,
    AXIS_Y = 2'd1,
    AXIS_Z = 2'd2
  } axis_sel;

  typedef struct packed {
    logic    en;
    axis_sel axis;
    coord    pos;
    material mat;
  } object;

  typedef struct packed {
    logic    any;
    axis_sel axis;
    coord    num;
    coord    den;
    coord    pos;
    material mat;
  } hit_info;

  // Component of a vector along one axis
  function automatic coord vec_comp(vec3 v, axis_sel a);
    case (a)
      AXIS_X:  return v.x;
      AXIS_Y:  return v.y;
      default: return v.z;
    endcase
  endfunction

  // Magnitude as unsigned, so -32768 stays exact
  function automatic logic [15:0] abs_coord(coord c);
    return c[15] ? 16'(-c) : 16'(c);
  endfunction

endpackage
